// ==== src/iq_pkg.sv ====
package iq_pkg;

  // Opcode class, the only part of decode the queue cares about
  typedef enum logic [1:0] {
    op_alu    = 2'd0,
    op_load   = 2'd1,
    op_store  = 2'd2,
    op_branch = 2'd3
  } opcode_e;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // One instruction word as stored in the queue, 32 bits
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    dest;
    reg_idx_t    src_a;
    reg_idx_t    src_b;
    logic [14:0] imm;
  } instr_t;

  // Two instructions side by side
  // slot0 is the older one
  typedef struct packed {
    instr_t slot1;
    instr_t slot0;
  } instr_pair_t;

  // Total queue depth, split evenly over two banks
  localparam int IQ_DEPTH_DEFAULT = 8;

endpackage

// ==== src/fifo_flopped.sv ====
`timescale 1ns/10ps

module fifo_flopped #(
  parameter int DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  iq_pkg::instr_t in_data,
  input  logic           push,
  input  logic           pop,
  output iq_pkg::instr_t out_data,
  output logic           full,
  output logic           empty,
  output logic           idle
);
  import iq_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  instr_t             mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  // Nothing stored and nothing arriving
  assign idle  = empty && !push;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Show-ahead head
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/fifo_flopped_2w2r.sv ====
`timescale 1ns/10ps

module fifo_flopped_2w2r #(
  parameter int DEPTH = iq_pkg::IQ_DEPTH_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                push0,
  input  logic                push1,
  input  iq_pkg::instr_pair_t in_pair,
  input  logic                pop0,
  input  logic                pop1,
  output iq_pkg::instr_pair_t out_pair,
  output logic                full,
  output logic                one_left_to_full,
  output logic                empty,
  output logic                one_left_to_empty,
  output logic                idle
);
  import iq_pkg::*;

  localparam int BANK_DEPTH = DEPTH / 2;

  logic   push_swap;
  logic   pop_swap;
  logic   push_even, push_odd;
  logic   pop_even, pop_odd;
  instr_t in_even, in_odd;
  instr_t out_even, out_odd;
  logic   full_even, full_odd;
  logic   empty_even, empty_odd;
  logic   idle_even, idle_odd;

  // Push side, swap set means the odd bank takes the next entry
  always_ff @(posedge clk) begin
    if (rst) begin
      push_swap <= 1'b0;
    end else if (push0 && !push1) begin
      push_swap <= !push_swap;
    end
  end

  assign {push_odd, push_even} = push_swap ? {push0, push1} : {push1, push0};
  assign {in_odd, in_even}     = push_swap ? {in_pair.slot0, in_pair.slot1}
                                           : {in_pair.slot1, in_pair.slot0};

  // Pop side, swap set means the oldest entry sits in the odd bank
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_swap <= 1'b0;
    end else if (pop0 && !pop1) begin
      pop_swap <= !pop_swap;
    end
  end

  assign {pop_odd, pop_even} = pop_swap ? {pop0, pop1} : {pop1, pop0};
  assign out_pair.slot0      = pop_swap ? out_odd : out_even;
  assign out_pair.slot1      = pop_swap ? out_even : out_odd;

  // Bank counts differ by at most one
  assign full              = full_even && full_odd;
  assign one_left_to_full  = full_even ^ full_odd;
  assign empty             = empty_even && empty_odd;
  assign one_left_to_empty = empty_even ^ empty_odd;
  assign idle              = idle_even && idle_odd;

  // Entries 0, 2, 4, ...
  fifo_flopped #(.DEPTH(BANK_DEPTH)) bank_even (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_even),
    .push     (push_even),
    .pop      (pop_even),
    .out_data (out_even),
    .full     (full_even),
    .empty    (empty_even),
    .idle     (idle_even)
  );

  // Entries 1, 3, 5, ...
  fifo_flopped #(.DEPTH(BANK_DEPTH)) bank_odd (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_odd),
    .push     (push_odd),
    .pop      (pop_odd),
    .out_data (out_odd),
    .full     (full_odd),
    .empty    (empty_odd),
    .idle     (idle_odd)
  );

endmodule

// ==== src/fetch_align.sv ====
`timescale 1ns/10ps

module fetch_align (
  input  logic                clk,
  input  logic                rst,
  input  logic [1:0]          fetch_valid,
  input  iq_pkg::instr_pair_t fetch_bundle,
  input  logic                full,
  input  logic                one_left_to_full,
  output logic                fetch_stall,
  output logic                push0,
  output logic                push1,
  output iq_pkg::instr_pair_t in_pair
);
  import iq_pkg::*;

  logic        hold_valid;
  logic        hold_two;
  instr_pair_t hold_pair;
  instr_pair_t packed_pair;
  logic        can_push;
  logic        accept;

  // Room for one needs not full, room for two needs two free entries
  assign can_push = hold_valid &&
                    (hold_two ? (!full && !one_left_to_full) : !full);

  assign fetch_stall = hold_valid && !can_push;
  assign accept      = !fetch_stall && (fetch_valid != 2'b00);

  // Lone slot 1 moves down to lane 0
  always_comb begin
    packed_pair = fetch_bundle;
    if (fetch_valid == 2'b10) begin
      packed_pair.slot0 = fetch_bundle.slot1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (accept) begin
      hold_valid <= 1'b1;
    end else if (can_push) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_pair <= packed_pair;
      hold_two  <= (fetch_valid == 2'b11);
    end
  end

  assign push0   = can_push;
  assign push1   = can_push && hold_two;
  assign in_pair = hold_pair;

endmodule

// ==== src/issue_pair.sv ====
`timescale 1ns/10ps

module issue_pair (
  input  logic                clk,
  input  logic                rst,
  input  iq_pkg::instr_pair_t out_pair,
  input  logic                empty,
  input  logic                one_left_to_empty,
  input  logic                issue_stall,
  output logic                pop0,
  output logic                pop1,
  output logic [1:0]          issue_valid,
  output iq_pkg::instr_pair_t issue_pair
);
  import iq_pkg::*;

  instr_t head;
  instr_t next;
  logic   two_stored;
  logic   raw_hazard;
  logic   head_branch;
  logic   pairable;

  assign head = out_pair.slot0;
  assign next = out_pair.slot1;

  assign two_stored  = !empty && !one_left_to_empty;
  assign head_branch = (head.opcode == op_branch);

  // Second one reads what the first one writes
  assign raw_hazard = (next.src_a == head.dest) || (next.src_b == head.dest);

  assign pairable = two_stored && !head_branch && !raw_hazard;

  assign pop0 = !issue_stall && !empty;
  assign pop1 = pop0 && pairable;

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 2'b00;
    end else begin
      issue_valid <= {pop1, pop0};
    end
  end

  // Payload only matters where issue_valid is set
  always_ff @(posedge clk) begin
    if (pop0) begin
      issue_pair <= out_pair;
    end
  end

endmodule

// ==== src/iq_top.sv ====
`timescale 1ns/10ps

module iq_top #(
  parameter int DEPTH = iq_pkg::IQ_DEPTH_DEFAULT
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [1:0]          fetch_valid,
  input  iq_pkg::instr_pair_t fetch_bundle,
  input  logic                issue_stall,
  output logic                fetch_stall,
  output logic [1:0]          issue_valid,
  output iq_pkg::instr_pair_t issue_pair,
  output logic                queue_idle
);
  import iq_pkg::*;

  logic        push0, push1;
  logic        pop0, pop1;
  instr_pair_t in_pair;
  instr_pair_t out_pair;
  logic        full, one_left_to_full;
  logic        empty, one_left_to_empty;

  fetch_align u_fetch_align (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid      (fetch_valid),
    .fetch_bundle     (fetch_bundle),
    .full             (full),
    .one_left_to_full (one_left_to_full),
    .fetch_stall      (fetch_stall),
    .push0            (push0),
    .push1            (push1),
    .in_pair          (in_pair)
  );

  fifo_flopped_2w2r #(.DEPTH(DEPTH)) u_queue (
    .clk               (clk),
    .rst               (rst),
    .push0             (push0),
    .push1             (push1),
    .in_pair           (in_pair),
    .pop0              (pop0),
    .pop1              (pop1),
    .out_pair          (out_pair),
    .full              (full),
    .one_left_to_full  (one_left_to_full),
    .empty             (empty),
    .one_left_to_empty (one_left_to_empty),
    .idle              (queue_idle)
  );

  issue_pair u_issue_pair (
    .clk               (clk),
    .rst               (rst),
    .out_pair          (out_pair),
    .empty             (empty),
    .one_left_to_empty (one_left_to_empty),
    .issue_stall       (issue_stall),
    .pop0              (pop0),
    .pop1              (pop1),
    .issue_valid       (issue_valid),
    .issue_pair        (issue_pair)
  );

endmodule

// ==== tests/tb_iq_top.sv ====
`timescale 1ns/10ps

module tb_iq_top;
  import iq_pkg::*;

  localparam int DEPTH        = IQ_DEPTH_DEFAULT;
  localparam int RAND_CYCLES  = 300;
  localparam int SINGLE_CYCLES = 100;
  localparam int FILL_CYCLES  = DEPTH + 8;
  localparam int DRAIN_CYCLES = 4 * DEPTH + 20;
  localparam int TOTAL_CYCLES = 5 + RAND_CYCLES + SINGLE_CYCLES + FILL_CYCLES
                                + 4 * DRAIN_CYCLES;

  logic        clk = 1'b0;
  logic        rst;
  logic [1:0]  fetch_valid;
  instr_pair_t fetch_bundle;
  logic        issue_stall;
  logic        fetch_stall;
  logic [1:0]  issue_valid;
  instr_pair_t issue_pair;
  logic        queue_idle;

  instr_t model[$];
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int test_start_errors = 0;
  int phase_accepted = 0;
  int stall_edges = 0;
  int pair_count = 0;
  bit bp_mode = 0;
  bit expect_pairs = 0;

  iq_top #(.DEPTH(DEPTH)) UUT (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch_bundle (fetch_bundle),
    .issue_stall  (issue_stall),
    .fetch_stall  (fetch_stall),
    .issue_valid  (issue_valid),
    .issue_pair   (issue_pair),
    .queue_idle   (queue_idle)
  );

  always #20 clk = ~clk;

  // Run limit of twice the expected length
  initial begin
    #(2 * TOTAL_CYCLES * 40);
    $display("Timeout, the run did not finish in %0d cycles", 2 * TOTAL_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    errors++;
  endtask

  // Register fields from 0..3 so hazards show up often
  function automatic instr_t random_instr(input bit alu_only);
    instr_t i;
    i.opcode = alu_only ? op_alu : opcode_e'(2'($urandom_range(0, 3)));
    i.dest   = alu_only ? reg_idx_t'($urandom_range(16, 31)) : reg_idx_t'($urandom_range(0, 3));
    i.src_a  = reg_idx_t'($urandom_range(0, 3));
    i.src_b  = reg_idx_t'($urandom_range(0, 3));
    i.imm    = 15'($urandom);
    return i;
  endfunction

  task automatic check_lane(input string name, input instr_t act);
    instr_t exp;
    assert (model.size() > 0) else begin
      $display("Error at %0t, %s issued while no instruction was pending", $time, name);
      errors++;
    end
    if (model.size() > 0) begin
      exp = model.pop_front();
      assert (act == exp) else value_error(name, exp, act);
    end
  endtask

  task automatic check_issue();
    assert (issue_valid != 2'b10) else value_error("issue_valid", 32'h3, 32'(issue_valid));
    if (issue_valid == 2'b11) begin
      pair_count++;
      assert (issue_pair.slot0.opcode != op_branch) else
        value_error("issue_pair.slot0.opcode", 32'(op_alu), 32'(issue_pair.slot0.opcode));
      assert (issue_pair.slot1.src_a != issue_pair.slot0.dest &&
              issue_pair.slot1.src_b != issue_pair.slot0.dest) else begin
        $display("Error at %0t, pair issued with a dependency on lane 0 dest", $time);
        errors++;
      end
    end
    if (expect_pairs) begin
      assert (issue_valid != 2'b01) else value_error("issue_valid", 32'h3, 32'(issue_valid));
    end
    if (bp_mode) begin
      stall_edges++;
      if (stall_edges >= 2) begin
        assert (issue_valid == 2'b00) else value_error("issue_valid", 32'h0, 32'(issue_valid));
      end
    end
    if (issue_valid[0]) check_lane("issue_pair.slot0", issue_pair.slot0);
    if (issue_valid[1]) check_lane("issue_pair.slot1", issue_pair.slot1);
  endtask

  // One cycle that checks outputs and drives inputs at the falling edge
  task automatic step(input logic [1:0] fv, input instr_pair_t b, input logic stall);
    @(negedge clk);
    check_issue();
    // Queue and holding register are both full by now
    if (bp_mode && phase_accepted >= DEPTH + 2) begin
      assert (fetch_stall) else value_error("fetch_stall", 32'h1, 32'(fetch_stall));
    end
    issue_stall = stall;
    if (!fetch_stall) begin
      fetch_valid  = fv;
      fetch_bundle = b;
      if (fv[0]) model.push_back(b.slot0);
      if (fv[1]) model.push_back(b.slot1);
      if (fv != 2'b00) phase_accepted += (fv == 2'b11) ? 2 : 1;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((model.size() != 0 || !queue_idle || fetch_stall) && n < DRAIN_CYCLES) begin
      step(2'b00, fetch_bundle, 1'b0);
      n++;
    end
    step(2'b00, fetch_bundle, 1'b0);
    assert (model.size() == 0 && queue_idle) else begin
      $display("Error at %0t, queue did not drain, %0d instructions pending", $time, model.size());
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail, %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  initial begin
    instr_pair_t b;
    logic stall;
    int burst;
    void'($urandom(32'h5cb8));
    rst          = 1'b1;
    fetch_valid  = 2'b00;
    fetch_bundle = '0;
    issue_stall  = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (!fetch_stall) else value_error("fetch_stall", 32'h0, 32'(fetch_stall));
    assert (issue_valid == 2'b00) else value_error("issue_valid", 32'h0, 32'(issue_valid));
    assert (queue_idle) else value_error("queue_idle", 32'h1, 32'(queue_idle));
    end_test("reset state");

    // Random traffic with stall bursts
    stall = 1'b0;
    burst = 0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      if (burst == 0) begin
        stall = ($urandom_range(0, 3) == 0);
        burst = $urandom_range(1, 6);
      end
      burst--;
      b.slot0 = random_instr(1'b0);
      b.slot1 = random_instr(1'b0);
      step(2'($urandom_range(0, 3)), b, stall);
    end
    drain();
    end_test("random order and pairing");

    // Only slot 1 valid
    for (int c = 0; c < SINGLE_CYCLES; c++) begin
      b.slot0 = random_instr(1'b0);
      b.slot1 = random_instr(1'b0);
      step($urandom_range(0, 1) ? 2'b10 : 2'b00, b, 1'($urandom_range(0, 4) == 0));
    end
    drain();
    end_test("single slot bundles");

    // Fill with independent ALU pairs under a held stall
    phase_accepted = 0;
    stall_edges    = 0;
    bp_mode        = 1;
    for (int c = 0; c < FILL_CYCLES; c++) begin
      b.slot0 = random_instr(1'b1);
      b.slot1 = random_instr(1'b1);
      step(2'b11, b, 1'b1);
    end
    bp_mode = 0;
    step(2'b00, b, 1'b1);
    assert (fetch_stall) else value_error("fetch_stall", 32'h1, 32'(fetch_stall));
    end_test("back-pressure");

    pair_count   = 0;
    expect_pairs = 1;
    drain();
    expect_pairs = 0;
    assert (pair_count > 0) else begin
      $display("Error at %0t, no pair was issued from a full queue", $time);
      errors++;
    end
    end_test("dual issue");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
src/iq_pkg.sv
src/fifo_flopped.sv
src/fifo_flopped_2w2r.sv
src/fetch_align.sv
src/issue_pair.sv
src/iq_top.sv
tests/tb_iq_top.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_iq_top -f build.f -o sim_iq \
  || { echo "Build failed"; exit 1; }
./obj_dir/sim_iq > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
  || echo "Simulation finished without failures"
